/* src/layer_pkg.sv */
package layer_pkg;

	// Bus word sizes
	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int FUNC_WIDTH = 4;

	// Local storage word sizes
	localparam int RF_DATA_WIDTH = 24;
	localparam int MEM_DATA_WIDTH = 32;

	// Function id carried in the low nibble of a bus address
	typedef enum logic [FUNC_WIDTH-1:0] {
		LC_FUNC_RF_WRITE  = 4'd0,
		LC_FUNC_RF_READ   = 4'd1,
		LC_FUNC_MEM_WRITE = 4'd2,
		LC_FUNC_MEM_READ  = 4'd3,
		LC_FUNC_REPLY     = 4'd4
	} lc_func_e;

	// Layer controller sequencing
	typedef enum logic [2:0] {
		LC_ST_IDLE,
		LC_ST_RX_WAIT,
		LC_ST_PROC,
		LC_ST_MEM,
		LC_ST_TX,
		LC_ST_TX_RESP,
		LC_ST_INT_CLR
	} lc_state_e;

endpackage

/* src/layer_ctrl.sv */
`timescale 1ns/1ps

module layer_ctrl
	import layer_pkg::*;
#(
	parameter int RF_NUM = 8,
	parameter int MEM_DEPTH = 64,
	parameter logic [ADDR_WIDTH-1:0] IRQ_DEST = 8'hE4
)
(
	input  logic CLK,
	input  logic RESETn_local,
	// Bus receiver side
	input  logic [ADDR_WIDTH-1:0] rx_addr,
	input  logic [DATA_WIDTH-1:0] rx_data,
	input  logic rx_pend,
	input  logic rx_req,
	output logic rx_ack,
	// Bus transmitter side
	output logic [ADDR_WIDTH-1:0] tx_addr,
	output logic [DATA_WIDTH-1:0] tx_data,
	output logic tx_pend,
	output logic tx_req,
	input  logic tx_ack,
	input  logic tx_succ,
	input  logic tx_fail,
	output logic tx_resp_ack,
	input  logic interrupt,
	output logic clr_int,
	// Register file
	input  logic [RF_NUM*RF_DATA_WIDTH-1:0] rf_din,
	output logic [RF_DATA_WIDTH-1:0] rf_dout,
	output logic [RF_NUM-1:0] rf_load,
	// Memory port
	output logic mem_req,
	output logic mem_write,
	output logic [$clog2(MEM_DEPTH)-1:0] mem_addr,
	output logic [MEM_DATA_WIDTH-1:0] mem_wdata,
	input  logic mem_ack,
	input  logic [MEM_DATA_WIDTH-1:0] mem_rdata
);
	localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);
	localparam int IDX_WIDTH = DATA_WIDTH - RF_DATA_WIDTH;
	localparam int RF_IDX_WIDTH = (RF_NUM > 1) ? $clog2(RF_NUM) : 1;
	localparam int PREFIX_WIDTH = ADDR_WIDTH - FUNC_WIDTH;

	lc_state_e state, next_state;
	lc_func_e rx_func, next_rx_func;
	logic [PREFIX_WIDTH-1:0] rx_prefix, next_rx_prefix;
	logic [DATA_WIDTH-1:0] rx_word, next_rx_word;
	logic rx_pend_q, next_rx_pend_q;
	logic first_word, next_first_word;
	logic [IDX_WIDTH-1:0] rd_cnt, next_rd_cnt;
	logic int_d, int_pend, next_int_pend;
	logic irq_busy, next_irq_busy;

	logic next_rx_ack, next_tx_pend, next_tx_req, next_tx_resp_ack, next_clr_int;
	logic [ADDR_WIDTH-1:0] next_tx_addr;
	logic [DATA_WIDTH-1:0] next_tx_data;
	logic [RF_DATA_WIDTH-1:0] next_rf_dout;
	logic [RF_NUM-1:0] next_rf_load;
	logic next_mem_req, next_mem_write;
	logic [MEM_ADDR_WIDTH-1:0] next_mem_addr;
	logic [MEM_DATA_WIDTH-1:0] next_mem_wdata;

	logic [RF_DATA_WIDTH-1:0] rf_word [RF_NUM];
	logic [IDX_WIDTH-1:0] word_idx;
	logic [RF_IDX_WIDTH-1:0] rf_idx;
	logic idx_ok;
	logic [ADDR_WIDTH-1:0] reply_addr;

	for (genvar g = 0; g < RF_NUM; g++)
	begin : g_rf_unpack
		assign rf_word[g] = rf_din[g*RF_DATA_WIDTH +: RF_DATA_WIDTH];
	end

	// Register index sits in the top byte of a word
	assign word_idx = rx_word[DATA_WIDTH-1 -: IDX_WIDTH];
	assign rf_idx = word_idx[RF_IDX_WIDTH-1:0];
	assign idx_ok = (word_idx < RF_NUM);
	assign reply_addr = {rx_prefix, LC_FUNC_REPLY};

	always_ff @(posedge CLK or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state <= LC_ST_IDLE;
			rx_func <= LC_FUNC_RF_WRITE;
			rx_pend_q <= 1'b0;
			first_word <= 1'b0;
			rd_cnt <= '0;
			int_d <= 1'b0;
			int_pend <= 1'b0;
			irq_busy <= 1'b0;
			rx_ack <= 1'b0;
			tx_pend <= 1'b0;
			tx_req <= 1'b0;
			tx_resp_ack <= 1'b0;
			clr_int <= 1'b0;
			rf_load <= '0;
			mem_req <= 1'b0;
			mem_write <= 1'b0;
		end
		else
		begin
			state <= next_state;
			rx_func <= next_rx_func;
			rx_pend_q <= next_rx_pend_q;
			first_word <= next_first_word;
			rd_cnt <= next_rd_cnt;
			int_d <= interrupt;
			int_pend <= next_int_pend;
			irq_busy <= next_irq_busy;
			rx_ack <= next_rx_ack;
			tx_pend <= next_tx_pend;
			tx_req <= next_tx_req;
			tx_resp_ack <= next_tx_resp_ack;
			clr_int <= next_clr_int;
			rf_load <= next_rf_load;
			mem_req <= next_mem_req;
			mem_write <= next_mem_write;
		end
	end

	// Data words and addresses
	always_ff @(posedge CLK)
	begin
		rx_prefix <= next_rx_prefix;
		rx_word <= next_rx_word;
		tx_addr <= next_tx_addr;
		tx_data <= next_tx_data;
		rf_dout <= next_rf_dout;
		mem_addr <= next_mem_addr;
		mem_wdata <= next_mem_wdata;
	end

	always_comb
	begin
		next_state = state;
		next_rx_func = rx_func;
		next_rx_prefix = rx_prefix;
		next_rx_word = rx_word;
		next_rx_pend_q = rx_pend_q;
		next_first_word = first_word;
		next_rd_cnt = rd_cnt;
		next_int_pend = int_pend;
		next_irq_busy = irq_busy;
		next_rx_ack = rx_ack;
		next_tx_addr = tx_addr;
		next_tx_data = tx_data;
		next_tx_pend = tx_pend;
		next_tx_req = tx_req;
		next_tx_resp_ack = tx_resp_ack;
		next_clr_int = clr_int;
		next_rf_dout = rf_dout;
		next_rf_load = '0;
		next_mem_req = mem_req;
		next_mem_write = mem_write;
		next_mem_addr = mem_addr;
		next_mem_wdata = mem_wdata;

		// Release of rx_ack may happen in any state
		if (rx_ack && !rx_req)
			next_rx_ack = 1'b0;
		if (interrupt && !int_d)
			next_int_pend = 1'b1;

		case (state)
			LC_ST_IDLE:
			begin
				// Interrupt wins over a waiting message
				if (int_pend)
				begin
					next_int_pend = 1'b0;
					next_irq_busy = 1'b1;
					next_tx_addr = IRQ_DEST;
					next_tx_data = {{IDX_WIDTH{1'b1}}, rf_word[0]};
					next_tx_pend = 1'b0;
					next_tx_req = 1'b1;
					next_state = LC_ST_TX;
				end
				else if (rx_req && !rx_ack)
				begin
					next_rx_ack = 1'b1;
					next_rx_prefix = rx_addr[ADDR_WIDTH-1 -: PREFIX_WIDTH];
					next_rx_func = lc_func_e'(rx_addr[FUNC_WIDTH-1:0]);
					next_rx_word = rx_data;
					next_rx_pend_q = rx_pend;
					next_first_word = 1'b1;
					next_state = LC_ST_PROC;
				end
			end

			LC_ST_RX_WAIT:
			begin
				if (rx_req && !rx_ack)
				begin
					next_rx_ack = 1'b1;
					next_rx_word = rx_data;
					next_rx_pend_q = rx_pend;
					next_state = LC_ST_PROC;
				end
			end

			LC_ST_PROC:
			begin
				next_first_word = 1'b0;
				case (rx_func)
					LC_FUNC_RF_WRITE:
					begin
						if (idx_ok)
						begin
							next_rf_dout = rx_word[RF_DATA_WIDTH-1:0];
							next_rf_load[rf_idx] = 1'b1;
						end
						next_state = rx_pend_q ? LC_ST_RX_WAIT : LC_ST_IDLE;
					end
					LC_FUNC_RF_READ:
					begin
						// No reply at all for a bad index
						if (idx_ok)
						begin
							next_tx_addr = reply_addr;
							next_tx_data = {word_idx, rf_word[rf_idx]};
							next_tx_pend = 1'b0;
							next_tx_req = 1'b1;
							next_state = LC_ST_TX;
						end
						else
							next_state = LC_ST_IDLE;
					end
					LC_FUNC_MEM_WRITE:
					begin
						if (first_word)
						begin
							next_mem_addr = rx_word[MEM_ADDR_WIDTH-1:0];
							next_state = rx_pend_q ? LC_ST_RX_WAIT : LC_ST_IDLE;
						end
						else
						begin
							next_mem_wdata = rx_word;
							next_mem_write = 1'b1;
							next_mem_req = 1'b1;
							next_state = LC_ST_MEM;
						end
					end
					LC_FUNC_MEM_READ:
					begin
						next_rd_cnt = word_idx;
						next_mem_addr = rx_word[MEM_ADDR_WIDTH-1:0];
						next_mem_write = 1'b0;
						next_mem_req = 1'b1;
						next_state = LC_ST_MEM;
					end
					default:
						next_state = LC_ST_IDLE;
				endcase
			end

			LC_ST_MEM:
			begin
				if (mem_req && mem_ack)
					next_mem_req = 1'b0;
				else if (!mem_req && !mem_ack)
				begin
					// Running address wraps at the top of memory
					next_mem_addr = mem_addr + 1'b1;
					if (mem_write)
						next_state = rx_pend_q ? LC_ST_RX_WAIT : LC_ST_IDLE;
					else
					begin
						next_tx_addr = reply_addr;
						next_tx_data = mem_rdata;
						next_tx_pend = (rd_cnt != '0);
						next_tx_req = 1'b1;
						next_rd_cnt = rd_cnt - 1'b1;
						next_state = LC_ST_TX;
					end
				end
			end

			LC_ST_TX:
			begin
				if (tx_req && tx_ack)
					next_tx_req = 1'b0;
				else if (!tx_req && !tx_ack)
				begin
					// More burst words to fetch, or wait for the verdict
					if (tx_pend)
					begin
						next_mem_req = 1'b1;
						next_state = LC_ST_MEM;
					end
					else
						next_state = LC_ST_TX_RESP;
				end
			end

			LC_ST_TX_RESP:
			begin
				if (!tx_resp_ack && (tx_succ || tx_fail))
					next_tx_resp_ack = 1'b1;
				else if (tx_resp_ack && !tx_succ && !tx_fail)
				begin
					next_tx_resp_ack = 1'b0;
					next_clr_int = irq_busy;
					next_state = irq_busy ? LC_ST_INT_CLR : LC_ST_IDLE;
				end
			end

			LC_ST_INT_CLR:
			begin
				if (clr_int && !interrupt)
				begin
					next_clr_int = 1'b0;
					next_irq_busy = 1'b0;
					next_state = LC_ST_IDLE;
				end
			end

			default:
				next_state = LC_ST_IDLE;
		endcase
	end

endmodule

/* src/layer_reg_file.sv */
`timescale 1ns/1ps

module layer_reg_file
	import layer_pkg::*;
#(
	parameter int RF_NUM = 8
)
(
	input  logic CLK,
	input  logic RESETn_local,
	input  logic [RF_NUM-1:0] rf_load,
	input  logic [RF_DATA_WIDTH-1:0] rf_dout,
	output logic [RF_NUM*RF_DATA_WIDTH-1:0] rf_din
);
	logic [RF_DATA_WIDTH-1:0] rf_reg [RF_NUM];

	// One-hot load, so at most one register changes per cycle
	always_ff @(posedge CLK or negedge RESETn_local)
	begin
		if (!RESETn_local)
			rf_reg <= '{default: '0};
		else
		begin
			for (int i = 0; i < RF_NUM; i++)
			begin
				if (rf_load[i])
					rf_reg[i] <= rf_dout;
			end
		end
	end

	// Register 0 ends up in the low bits
	for (genvar g = 0; g < RF_NUM; g++)
	begin : g_rf_pack
		assign rf_din[g*RF_DATA_WIDTH +: RF_DATA_WIDTH] = rf_reg[g];
	end

endmodule

/* src/layer_mem.sv */
`timescale 1ns/1ps

module layer_mem
	import layer_pkg::*;
#(
	parameter int MEM_DEPTH = 64
)
(
	input  logic CLK,
	input  logic RESETn_local,
	input  logic mem_req,
	input  logic mem_write,
	input  logic [$clog2(MEM_DEPTH)-1:0] mem_addr,
	input  logic [MEM_DATA_WIDTH-1:0] mem_wdata,
	output logic mem_ack,
	output logic [MEM_DATA_WIDTH-1:0] mem_rdata
);
	logic [MEM_DATA_WIDTH-1:0] mem_array [MEM_DEPTH];
	logic acc_done;
	logic acc_start;

	// Only the first cycle of a held request does the access
	assign acc_start = mem_req && !acc_done;

	always_ff @(posedge CLK or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			acc_done <= 1'b0;
			mem_ack <= 1'b0;
		end
		else
		begin
			if (!mem_req)
				acc_done <= 1'b0;
			else if (acc_start)
				acc_done <= 1'b1;
			// Ack follows the access by one cycle, drops with the request
			mem_ack <= mem_req && acc_done;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (acc_start)
		begin
			if (mem_write)
				mem_array[mem_addr] <= mem_wdata;
			else
				mem_rdata <= mem_array[mem_addr];
		end
	end

endmodule

/* src/layer_top.sv */
`timescale 1ns/1ps

module layer_top
	import layer_pkg::*;
#(
	parameter int RF_NUM = 8,
	parameter int MEM_DEPTH = 64,
	parameter logic [ADDR_WIDTH-1:0] IRQ_DEST = 8'hE4
)
(
	input  logic CLK,
	input  logic RESETn_local,
	input  logic [ADDR_WIDTH-1:0] rx_addr,
	input  logic [DATA_WIDTH-1:0] rx_data,
	input  logic rx_pend,
	input  logic rx_req,
	output logic rx_ack,
	output logic [ADDR_WIDTH-1:0] tx_addr,
	output logic [DATA_WIDTH-1:0] tx_data,
	output logic tx_pend,
	output logic tx_req,
	input  logic tx_ack,
	input  logic tx_succ,
	input  logic tx_fail,
	output logic tx_resp_ack,
	input  logic interrupt,
	output logic clr_int
);
	localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);

	// Register file link
	logic [RF_NUM*RF_DATA_WIDTH-1:0] rf_din;
	logic [RF_DATA_WIDTH-1:0] rf_dout;
	logic [RF_NUM-1:0] rf_load;

	// Memory link
	logic mem_req;
	logic mem_write;
	logic [MEM_ADDR_WIDTH-1:0] mem_addr;
	logic [MEM_DATA_WIDTH-1:0] mem_wdata;
	logic mem_ack;
	logic [MEM_DATA_WIDTH-1:0] mem_rdata;

	layer_ctrl #(
		.RF_NUM    (RF_NUM),
		.MEM_DEPTH (MEM_DEPTH),
		.IRQ_DEST  (IRQ_DEST)
	) ctrl_i (
		.CLK          (CLK),
		.RESETn_local (RESETn_local),
		.rx_addr      (rx_addr),
		.rx_data      (rx_data),
		.rx_pend      (rx_pend),
		.rx_req       (rx_req),
		.rx_ack       (rx_ack),
		.tx_addr      (tx_addr),
		.tx_data      (tx_data),
		.tx_pend      (tx_pend),
		.tx_req       (tx_req),
		.tx_ack       (tx_ack),
		.tx_succ      (tx_succ),
		.tx_fail      (tx_fail),
		.tx_resp_ack  (tx_resp_ack),
		.interrupt    (interrupt),
		.clr_int      (clr_int),
		.rf_din       (rf_din),
		.rf_dout      (rf_dout),
		.rf_load      (rf_load),
		.mem_req      (mem_req),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_ack      (mem_ack),
		.mem_rdata    (mem_rdata)
	);

	layer_reg_file #(
		.RF_NUM (RF_NUM)
	) reg_file_i (
		.CLK          (CLK),
		.RESETn_local (RESETn_local),
		.rf_load      (rf_load),
		.rf_dout      (rf_dout),
		.rf_din       (rf_din)
	);

	layer_mem #(
		.MEM_DEPTH (MEM_DEPTH)
	) mem_i (
		.CLK          (CLK),
		.RESETn_local (RESETn_local),
		.mem_req      (mem_req),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_ack      (mem_ack),
		.mem_rdata    (mem_rdata)
	);

endmodule

/* test/tb_layer_tasks.svh */
// Compare one value against its expected value
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp)
	begin
		$display("ERR %s: expected 0x%08h, got 0x%08h", name, exp, got);
		errors++;
	end
endtask

function automatic logic watched_level(input int which);
	if (which == WATCH_CLR_INT)
		return clr_int;
	return rx_ack;
endfunction

task automatic wait_for_level(input int which, input logic level, input string what);
	int waited;
	waited = 0;
	while (watched_level(which) !== level && waited < STEP_TIMEOUT)
	begin
		@(negedge CLK);
		waited++;
	end
	if (watched_level(which) !== level)
	begin
		$display("Timed out waiting for %s", what);
		errors++;
	end
endtask

// Four-phase receive of every word in msg_q, pend on all but the last
task automatic send_msg(input logic [ADDR_WIDTH-1:0] addr);
	int n;
	n = msg_q.size();
	for (int i = 0; i < n; i++)
	begin
		@(negedge CLK);
		rx_addr = addr;
		rx_data = msg_q[i];
		rx_pend = (i != n - 1);
		rx_req = 1'b1;
		wait_for_level(WATCH_RX_ACK, 1'b1, "rx_ack to rise");
		rx_req = 1'b0;
		wait_for_level(WATCH_RX_ACK, 1'b0, "rx_ack to fall");
	end
endtask

task automatic expect_word(input logic [ADDR_WIDTH-1:0] exp_addr,
	input logic [DATA_WIDTH-1:0] exp_data, input logic exp_pend);
	int waited;
	logic [ADDR_WIDTH+DATA_WIDTH:0] word;
	waited = 0;
	while (tx_words.size() == 0 && waited < STEP_TIMEOUT)
	begin
		@(negedge CLK);
		waited++;
	end
	if (tx_words.size() == 0)
	begin
		$display("No reply word was sent, one was expected for address 0x%02h", exp_addr);
		errors++;
	end
	else
	begin
		word = tx_words.pop_front();
		check_value("tx_addr", 32'(word[DATA_WIDTH +: ADDR_WIDTH]), 32'(exp_addr));
		check_value("tx_data", word[DATA_WIDTH-1:0], exp_data);
		check_value("tx_pend", 32'(word[ADDR_WIDTH+DATA_WIDTH]), 32'(exp_pend));
	end
endtask

// Waits for all response handshakes, then makes sure nothing else was sent
task automatic drain_replies();
	int waited;
	waited = 0;
	while (resp_count < resp_expected && waited < STEP_TIMEOUT)
	begin
		@(negedge CLK);
		waited++;
	end
	if (resp_count < resp_expected)
	begin
		$display("Transmit response handshake did not complete, %0d of %0d done",
			resp_count, resp_expected);
		errors++;
	end
	repeat (20)
		@(negedge CLK);
	if (tx_words.size() != 0)
	begin
		$display("Found %0d reply words that no request asked for", tx_words.size());
		errors++;
		tx_words.delete();
	end
endtask

// Bad index gets no reply at all
task automatic read_reg(input logic [3:0] prefix, input int idx);
	msg_q.delete();
	msg_q.push_back({8'(idx), 24'h0});
	send_msg({prefix, LC_FUNC_RF_READ});
	if (idx < RF_NUM)
	begin
		resp_expected++;
		expect_word({prefix, LC_FUNC_REPLY}, {8'(idx), rf_model[idx]}, 1'b0);
	end
endtask

task automatic check_reset_state();
	check_value("rx_ack", 32'(rx_ack), 32'h0);
	check_value("tx_req", 32'(tx_req), 32'h0);
	check_value("tx_resp_ack", 32'(tx_resp_ack), 32'h0);
	check_value("clr_int", 32'(clr_int), 32'h0);
	for (int i = 0; i < RF_NUM; i++)
		read_reg(4'h1, i);
	drain_replies();
endtask

task automatic rf_write_read();
	logic [RF_DATA_WIDTH-1:0] val;
	msg_q.delete();
	for (int i = 0; i < RF_NUM; i++)
	begin
		val = 24'h5A0F00 + 24'(i * 24'h011111);
		msg_q.push_back({8'(i), val});
		rf_model[i] = val;
		// Out of range index that aliases onto register 1
		if (i == 1)
			msg_q.push_back({8'(RF_NUM + 1), 24'hBAD0BA});
	end
	send_msg({4'h3, LC_FUNC_RF_WRITE});
	for (int i = 0; i < RF_NUM; i++)
	begin
		read_reg(4'hA, i);
		if (i == 3)
			read_reg(4'hA, RF_NUM + 3);
	end
	drain_replies();
endtask

task automatic mem_wrap_burst();
	int start;
	int addr;
	logic [MEM_DATA_WIDTH-1:0] val;
	start = MEM_DEPTH - 2;
	msg_q.delete();
	msg_q.push_back(32'(start));
	// Burst from two below the top wraps to address 0
	for (int k = 0; k < 5; k++)
	begin
		val = 32'hC0DE0000 + 32'(k * 32'h00110101);
		msg_q.push_back(val);
		mem_model[(start + k) % MEM_DEPTH] = val;
	end
	send_msg({4'h6, LC_FUNC_MEM_WRITE});
	msg_q.delete();
	msg_q.push_back({8'd3, 24'(MEM_DEPTH - 1)});
	send_msg({4'h6, LC_FUNC_MEM_READ});
	resp_expected++;
	for (int k = 0; k < 4; k++)
	begin
		addr = (MEM_DEPTH - 1 + k) % MEM_DEPTH;
		expect_word({4'h6, LC_FUNC_REPLY}, mem_model[addr], k != 3);
	end
	drain_replies();
endtask

task automatic irq_message();
	@(negedge CLK);
	interrupt = 1'b1;
	resp_expected++;
	expect_word(IRQ_DEST, {8'hFF, rf_model[0]}, 1'b0);
	wait_for_level(WATCH_CLR_INT, 1'b1, "clr_int to rise");
	// clr_int holds while the line is still high
	repeat (4)
		@(negedge CLK);
	check_value("clr_int", 32'(clr_int), 32'h1);
	interrupt = 1'b0;
	wait_for_level(WATCH_CLR_INT, 1'b0, "clr_int to fall");
	drain_replies();
endtask

task automatic failed_send_recovery();
	fail_send = 1'b1;
	read_reg(4'h9, 2);
	drain_replies();
	check_value("tx_resp_ack", 32'(tx_resp_ack), 32'h0);
	fail_send = 1'b0;
	read_reg(4'h9, 5);
	read_reg(4'hC, RF_NUM - 1);
	drain_replies();
endtask

/* test/tb_layer_top.sv */
`timescale 1ns/1ps

module tb_layer_top
	import layer_pkg::*;
();
	localparam int RF_NUM = 8;
	localparam int MEM_DEPTH = 64;
	localparam logic [ADDR_WIDTH-1:0] IRQ_DEST = 8'hE4;
	localparam int NUM_TESTS = 5;
	localparam int STEP_TIMEOUT = 300;
	localparam int WATCH_RX_ACK = 0;
	localparam int WATCH_CLR_INT = 1;

	logic CLK;
	logic RESETn_local;
	logic [ADDR_WIDTH-1:0] rx_addr;
	logic [DATA_WIDTH-1:0] rx_data;
	logic rx_pend;
	logic rx_req;
	logic rx_ack;
	logic [ADDR_WIDTH-1:0] tx_addr;
	logic [DATA_WIDTH-1:0] tx_data;
	logic tx_pend;
	logic tx_req;
	logic tx_ack;
	logic tx_succ;
	logic tx_fail;
	logic tx_resp_ack;
	logic interrupt;
	logic clr_int;

	// Reference state of the register file and memory
	logic [RF_DATA_WIDTH-1:0] rf_model [RF_NUM];
	logic [MEM_DATA_WIDTH-1:0] mem_model [MEM_DEPTH];
	// Words of the next message to send
	logic [DATA_WIDTH-1:0] msg_q [$];
	// Transmitted words as {pend, addr, data}
	logic [ADDR_WIDTH+DATA_WIDTH:0] tx_words [$];
	int resp_count;
	int resp_expected;
	logic fail_send;
	integer seed;
	int errors;
	int checks;

	layer_top #(
		.RF_NUM    (RF_NUM),
		.MEM_DEPTH (MEM_DEPTH),
		.IRQ_DEST  (IRQ_DEST)
	) dut_i (
		.CLK          (CLK),
		.RESETn_local (RESETn_local),
		.rx_addr      (rx_addr),
		.rx_data      (rx_data),
		.rx_pend      (rx_pend),
		.rx_req       (rx_req),
		.rx_ack       (rx_ack),
		.tx_addr      (tx_addr),
		.tx_data      (tx_data),
		.tx_pend      (tx_pend),
		.tx_req       (tx_req),
		.tx_ack       (tx_ack),
		.tx_succ      (tx_succ),
		.tx_fail      (tx_fail),
		.tx_resp_ack  (tx_resp_ack),
		.interrupt    (interrupt),
		.clr_int      (clr_int)
	);

	`include "tb_layer_tasks.svh"

	initial
	begin
		CLK = 1'b0;
		forever
			#4 CLK = ~CLK;
	end

	// Watchdog sized from the number of tests
	initial
	begin
		repeat (NUM_TESTS * 2000)
			@(posedge CLK);
		$display("Watchdog expired after %0d cycles, the tests did not finish", NUM_TESTS * 2000);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// Bus transmitter model with random ack delay
	initial
	begin : tx_model
		int delay;
		logic last;
		forever
		begin
			@(negedge CLK);
			if (tx_req && !tx_ack)
			begin
				last = !tx_pend;
				tx_words.push_back({tx_pend, tx_addr, tx_data});
				delay = $unsigned($random(seed)) % 6;
				repeat (delay)
					@(negedge CLK);
				tx_ack = 1'b1;
				while (tx_req)
					@(negedge CLK);
				tx_ack = 1'b0;
				if (last)
				begin
					// Verdict for the whole message
					if (fail_send)
						tx_fail = 1'b1;
					else
						tx_succ = 1'b1;
					while (!tx_resp_ack)
						@(negedge CLK);
					tx_succ = 1'b0;
					tx_fail = 1'b0;
					while (tx_resp_ack)
						@(negedge CLK);
					resp_count++;
				end
			end
		end
	end

	initial
	begin
		seed = 32'hdab062fd;
		RESETn_local = 1'b0;
		rx_addr = '0;
		rx_data = '0;
		rx_pend = 1'b0;
		rx_req = 1'b0;
		tx_ack = 1'b0;
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		interrupt = 1'b0;
		fail_send = 1'b0;
		resp_count = 0;
		resp_expected = 0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < RF_NUM; i++)
			rf_model[i] = '0;
		repeat (5)
			@(posedge CLK);
		@(negedge CLK);
		RESETn_local = 1'b1;

		check_reset_state();
		rf_write_read();
		mem_wrap_burst();
		irq_message();
		failed_send_recovery();

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+test
src/layer_pkg.sv
src/layer_ctrl.sv
src/layer_reg_file.sv
src/layer_mem.sv
src/layer_top.sv
test/tb_layer_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_layer_top
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f vlog.f -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
	exit 0
fi

echo "Pass message not found in $LOG"
exit 1
